// File: logic/game_pkg.sv
package game_pkg;

   typedef logic signed [10:0] coord_t;          // screen coordinate, signed like the sync counters

   typedef struct packed {
      logic [9:0] x;                              // left column of the square
      logic [9:0] y;                              // top row of the square
   } pos_t;

   typedef struct packed {
      logic   hs;                                 // active low
      logic   vs;                                 // active low
      logic   active;                             // visible pixel
      logic   sof;                                // first active pixel of frame
      logic   eof;                                // last active pixel of frame
      logic   sol;                                // first active pixel of line
      logic   eol;                                // last active pixel of line
      coord_t spot_x;
      coord_t spot_y;
   } vga_timing_t;

   typedef struct packed {
      logic up;
      logic down;
      logic left;
      logic right;
   } pad_t;

   typedef logic [7:0] color_t;                   // rgb332

   typedef struct packed {
      logic [9:0] r;
      logic [9:0] g;
      logic [9:0] b;
   } rgb_t;                                       // dac format, 10 bits per channel

   // set 2 scan codes
   localparam logic [7:0] sc_break = 8'hF0;
   localparam logic [7:0] sc_ext   = 8'hE0;       // extended key prefix
   localparam logic [7:0] sc_w     = 8'h1D;
   localparam logic [7:0] sc_s     = 8'h1B;
   localparam logic [7:0] sc_a     = 8'h1C;
   localparam logic [7:0] sc_d     = 8'h23;
   localparam logic [7:0] sc_i     = 8'h43;
   localparam logic [7:0] sc_k     = 8'h42;
   localparam logic [7:0] sc_j     = 8'h3B;
   localparam logic [7:0] sc_l     = 8'h4B;

   localparam color_t color_p1 = 8'hE0;           // red
   localparam color_t color_p2 = 8'h1C;           // green

   function automatic rgb_t rgb332_to_rgb(input color_t c);
      rgb_t w;
      w.r = {c[7:5], c[7:5], c[7:5], c[7]};      // replicate top bits up to 10
      w.g = {c[4:2], c[4:2], c[4:2], c[4]};
      w.b = {5{c[1:0]}};
      return w;
   endfunction

   function automatic rgb_t gradient_rgb(input logic [7:0] x);
      rgb_t w;
      w.r = {x, x[7:6]};                          // ramps up left to right
      w.g = '0;
      w.b = {~x, ~x[7:6]};                        // ramps down
      return w;
   endfunction

endpackage

// File: logic/vga_sync.sv
module vga_sync #(
   parameter int h_active = 640,
   parameter int h_front  = 16,
   parameter int h_sync   = 96,
   parameter int h_back   = 48,
   parameter int v_active = 480,
   parameter int v_front  = 10,
   parameter int v_sync   = 2,
   parameter int v_back   = 33
) (
   input  logic                  clock_50,
   input  logic                  rst,
   output game_pkg::vga_timing_t timing
);
   import game_pkg::*;

   localparam int h_total = h_active + h_front + h_sync + h_back;
   localparam int v_total = v_active + v_front + v_sync + v_back;

   localparam logic [10:0] h_last     = 11'(h_total - 1);
   localparam logic [10:0] v_last     = 11'(v_total - 1);
   localparam logic [10:0] h_act_last = 11'(h_active - 1);
   localparam logic [10:0] v_act_last = 11'(v_active - 1);
   localparam logic [10:0] hs_start   = 11'(h_active + h_front);
   localparam logic [10:0] hs_end     = 11'(h_active + h_front + h_sync);
   localparam logic [10:0] vs_start   = 11'(v_active + v_front);
   localparam logic [10:0] vs_end     = 11'(v_active + v_front + v_sync);

   logic [10:0] h_cnt;                            // column, active pixels first
   logic [10:0] v_cnt;                            // line, active lines first
   logic        h_wrap;
   logic        v_wrap;
   logic        h_vis;
   logic        v_vis;

   assign h_wrap = (h_cnt == h_last);
   assign v_wrap = (v_cnt == v_last);
   assign h_vis  = (h_cnt <= h_act_last);
   assign v_vis  = (v_cnt <= v_act_last);

   always_ff @(posedge clock_50) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_wrap) begin
         h_cnt <= '0;                             // end of line
         v_cnt <= v_wrap ? 11'd0 : v_cnt + 11'd1;
      end else begin
         h_cnt <= h_cnt + 11'd1;
      end
   end

   // decode is registered so every field leaves on the same edge
   always_ff @(posedge clock_50) begin
      if (rst) begin
         timing <= '{hs: 1'b1, vs: 1'b1, default: '0};
      end else begin
         timing.hs     <= ~((h_cnt >= hs_start) && (h_cnt < hs_end));
         timing.vs     <= ~((v_cnt >= vs_start) && (v_cnt < vs_end)); // whole lines
         timing.active <= h_vis && v_vis;
         timing.sof    <= (h_cnt == 11'd0) && (v_cnt == 11'd0);
         timing.eof    <= (h_cnt == h_act_last) && (v_cnt == v_act_last);
         timing.sol    <= (h_cnt == 11'd0) && v_vis;
         timing.eol    <= (h_cnt == h_act_last) && v_vis;
         timing.spot_x <= coord_t'(h_cnt);
         timing.spot_y <= coord_t'(v_cnt);
      end
   end

endmodule

// File: logic/ps2_keyboard.sv
module ps2_keyboard (
   input  logic           clock_50,
   input  logic           rst,
   input  logic           ps2_clk,
   input  logic           ps2_dat,
   output game_pkg::pad_t pad_p1,
   output game_pkg::pad_t pad_p2,
   output logic [7:0]     scan_byte
);
   import game_pkg::*;

   logic [2:0]  clk_sync;                         // two sync flops plus last sample
   logic [1:0]  dat_sync;
   logic        clk_fall;
   logic [10:0] frame;                            // stop, parity, data, start
   logic [3:0]  bit_cnt;
   logic [11:0] idle_cnt;                         // cycles since last falling edge
   logic        frame_done;
   logic        frame_ok;
   logic [7:0]  rx_byte;
   logic        brk;                              // F0 seen
   logic        ext;                              // E0 seen

   assign clk_fall = clk_sync[2] & ~clk_sync[1];
   assign rx_byte  = frame[8:1];
   assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]); // start, stop, odd parity

   always_ff @(posedge clock_50) begin
      if (rst) begin
         clk_sync <= '1;                          // bus idles high
         dat_sync <= '1;
      end else begin
         clk_sync <= {clk_sync[1:0], ps2_clk};
         dat_sync <= {dat_sync[0], ps2_dat};
      end
   end

   always_ff @(posedge clock_50) begin
      if (clk_fall) begin
         frame <= {dat_sync[1], frame[10:1]};     // lsb arrives first
      end
   end

   always_ff @(posedge clock_50) begin
      if (rst) begin
         bit_cnt    <= '0;
         idle_cnt   <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         if (clk_fall) begin
            idle_cnt <= '0;
            if (bit_cnt == 4'd10) begin
               bit_cnt    <= '0;
               frame_done <= 1'b1;                // 11th bit in
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else if (bit_cnt != 4'd0) begin
            if (idle_cnt == '1) begin
               bit_cnt  <= '0;                    // stalled frame, start over
               idle_cnt <= '0;
            end else begin
               idle_cnt <= idle_cnt + 12'd1;
            end
         end
      end
   end

   always_ff @(posedge clock_50) begin
      if (rst) begin
         pad_p1    <= '0;
         pad_p2    <= '0;
         scan_byte <= '0;
         brk       <= 1'b0;
         ext       <= 1'b0;
      end else if (frame_done && frame_ok) begin  // bad frames dropped whole
         scan_byte <= rx_byte;
         if (rx_byte == sc_break) begin
            brk <= 1'b1;
         end else if (rx_byte == sc_ext) begin
            ext <= 1'b1;
         end else begin
            brk <= 1'b0;                          // prefixes end with any code
            ext <= 1'b0;
            if (!ext) begin                       // extended keys ignored
               case (rx_byte)
                  sc_w:    pad_p1.up    <= ~brk;
                  sc_s:    pad_p1.down  <= ~brk;
                  sc_a:    pad_p1.left  <= ~brk;
                  sc_d:    pad_p1.right <= ~brk;
                  sc_i:    pad_p2.up    <= ~brk;
                  sc_k:    pad_p2.down  <= ~brk;
                  sc_j:    pad_p2.left  <= ~brk;
                  sc_l:    pad_p2.right <= ~brk;
                  default: ;                      // unknown, display only
               endcase
            end
         end
      end
   end

endmodule

// File: logic/player_ctrl.sv
module player_ctrl #(
   parameter int h_active    = 640,
   parameter int v_active    = 480,
   parameter int sprite_size = 16,
   parameter int move_step   = 2
) (
   input  logic           clock_50,
   input  logic           rst,
   input  logic           sof,
   input  game_pkg::pad_t pad_p1,
   input  game_pkg::pad_t pad_p2,
   output game_pkg::pos_t pos_p1,
   output game_pkg::pos_t pos_p2
);
   import game_pkg::*;

   localparam logic [9:0]  x_max = 10'(h_active - sprite_size); // right edge
   localparam logic [9:0]  y_max = 10'(v_active - sprite_size); // bottom edge
   localparam logic [10:0] step  = 11'(move_step);

   pos_t nxt_p1;
   pos_t nxt_p2;

   // one axis, saturating at 0 and lim
   function automatic logic [9:0] step_axis(input logic [9:0] p,
                                            input logic       dec,
                                            input logic       inc,
                                            input logic [9:0] lim);
      logic [10:0] wide;
      logic [10:0] up_sum;
      wide   = {1'b0, p};
      up_sum = wide + step;
      if (inc && !dec) begin
         if (up_sum > {1'b0, lim}) begin
            return lim;                           // clamp at edge
         end
         return up_sum[9:0];
      end
      if (dec && !inc) begin
         if (wide < step) begin
            return '0;
         end
         return p - step[9:0];
      end
      return p;                                   // none or both keys
   endfunction

   always_comb begin
      nxt_p1.x = step_axis(pos_p1.x, pad_p1.left, pad_p1.right, x_max);
      nxt_p1.y = step_axis(pos_p1.y, pad_p1.up, pad_p1.down, y_max);
      nxt_p2.x = step_axis(pos_p2.x, pad_p2.left, pad_p2.right, x_max);
      nxt_p2.y = step_axis(pos_p2.y, pad_p2.up, pad_p2.down, y_max);
   end

   always_ff @(posedge clock_50) begin
      if (rst) begin
         pos_p1 <= '{x: 10'd0, y: 10'd0};         // top left
         pos_p2 <= '{x: x_max, y: y_max};         // bottom right
      end else if (sof) begin                     // once per frame
         pos_p1 <= nxt_p1;
         pos_p2 <= nxt_p2;
      end
   end

endmodule

// File: logic/sprite_layer.sv
module sprite_layer #(
   parameter int               sprite_size  = 16,
   parameter game_pkg::color_t player_color = game_pkg::color_p1
) (
   input  logic             clock_50,
   input  game_pkg::coord_t spot_x,
   input  game_pkg::coord_t spot_y,
   input  game_pkg::pos_t   pos,
   output logic             hit,
   output game_pkg::color_t color
);

   localparam logic signed [11:0] size_c = 12'(sprite_size);

   logic signed [11:0] dx;                        // offset from left column
   logic signed [11:0] dy;                        // offset from top row
   logic               in_x;
   logic               in_y;

   assign dx   = 12'(spot_x) - $signed({2'b00, pos.x});
   assign dy   = 12'(spot_y) - $signed({2'b00, pos.y});
   assign in_x = (dx >= 12'sd0) && (dx < size_c); // half open
   assign in_y = (dy >= 12'sd0) && (dy < size_c);

   always_ff @(posedge clock_50) begin
      hit   <= in_x && in_y;
      color <= (in_x && in_y) ? player_color : '0; // solid square
   end

endmodule

// File: logic/pixel_mixer.sv
module pixel_mixer (
   input  logic                  clock_50,
   input  logic                  rst,
   input  game_pkg::vga_timing_t timing,
   input  logic                  hit_p1,
   input  game_pkg::color_t      color_p1_in,
   input  logic                  hit_p2,
   input  game_pkg::color_t      color_p2_in,
   output logic                  vga_hs,
   output logic                  vga_vs,
   output logic                  vga_blank,
   output logic [9:0]            vga_r,
   output logic [9:0]            vga_g,
   output logic [9:0]            vga_b
);
   import game_pkg::*;

   vga_timing_t timing_d;                         // lines up with the sprite stage
   rgb_t        mix_rgb;
   rgb_t        out_rgb;

   always_ff @(posedge clock_50) begin
      if (rst) begin
         timing_d <= '{hs: 1'b1, vs: 1'b1, default: '0};
      end else begin
         timing_d <= timing;
      end
   end

   always_comb begin
      if (!timing_d.active) begin
         mix_rgb = '0;                            // black in blanking
      end else if (hit_p1) begin
         mix_rgb = rgb332_to_rgb(color_p1_in);    // player 1 on top
      end else if (hit_p2) begin
         mix_rgb = rgb332_to_rgb(color_p2_in);
      end else begin
         mix_rgb = gradient_rgb(timing_d.spot_x[7:0]);
      end
   end

   always_ff @(posedge clock_50) begin
      if (rst) begin
         vga_hs    <= 1'b1;
         vga_vs    <= 1'b1;
         vga_blank <= 1'b0;
         out_rgb   <= '0;
      end else begin
         vga_hs    <= timing_d.hs;                // 2 cycles after vga_sync
         vga_vs    <= timing_d.vs;
         vga_blank <= timing_d.active;            // high while displaying
         out_rgb   <= mix_rgb;
      end
   end

   assign vga_r = out_rgb.r;
   assign vga_g = out_rgb.g;
   assign vga_b = out_rgb.b;

endmodule

// File: logic/hex_display.sv
module hex_display (
   input  logic [31:0]     debug,
   output logic [7:0][6:0] hex                    // digit 0 is the low nibble
);

   // segments g..a, active low
   function automatic logic [6:0] seg7(input logic [3:0] n);
      case (n)
         4'h0:    return 7'b1000000;
         4'h1:    return 7'b1111001;
         4'h2:    return 7'b0100100;
         4'h3:    return 7'b0110000;
         4'h4:    return 7'b0011001;
         4'h5:    return 7'b0010010;
         4'h6:    return 7'b0000010;
         4'h7:    return 7'b1111000;
         4'h8:    return 7'b0000000;
         4'h9:    return 7'b0010000;
         4'hA:    return 7'b0001000;
         4'hB:    return 7'b0000011;              // lower case b
         4'hC:    return 7'b1000110;
         4'hD:    return 7'b0100001;              // lower case d
         4'hE:    return 7'b0000110;
         default: return 7'b0001110;              // F
      endcase
   endfunction

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         hex[i] = seg7(debug[i*4 +: 4]);
      end
   end

endmodule

// File: logic/bomber_top.sv
module bomber_top #(
   parameter int h_active    = 640,
   parameter int h_front     = 16,
   parameter int h_sync      = 96,
   parameter int h_back      = 48,
   parameter int v_active    = 480,
   parameter int v_front     = 10,
   parameter int v_sync      = 2,
   parameter int v_back      = 33,
   parameter int sprite_size = 16,
   parameter int move_step   = 2
) (
   input  logic       clock_50,
   input  logic       rst,
   input  logic       ps2_clk,
   input  logic       ps2_dat,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic       vga_blank,
   output logic [9:0] vga_r,
   output logic [9:0] vga_g,
   output logic [9:0] vga_b,
   output logic [6:0] hex0,
   output logic [6:0] hex1,
   output logic [6:0] hex2,
   output logic [6:0] hex3,
   output logic [6:0] hex4,
   output logic [6:0] hex5,
   output logic [6:0] hex6,
   output logic [6:0] hex7
);
   import game_pkg::*;

   vga_timing_t     timing;
   pad_t            pad_p1;
   pad_t            pad_p2;
   pos_t            pos_p1;
   pos_t            pos_p2;
   logic [7:0]      scan_byte;                    // last good byte from keyboard
   logic            hit_p1;
   logic            hit_p2;
   color_t          sprite_color_p1;
   color_t          sprite_color_p2;
   logic [31:0]     debug;
   logic [7:0][6:0] hex;

   vga_sync #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
   ) sync0 (.clock_50(clock_50), .rst(rst), .timing(timing));

   ps2_keyboard kbd (
      .clock_50(clock_50), .rst(rst), .ps2_clk(ps2_clk), .ps2_dat(ps2_dat),
      .pad_p1(pad_p1), .pad_p2(pad_p2), .scan_byte(scan_byte)
   );

   player_ctrl #(
      .h_active(h_active), .v_active(v_active),
      .sprite_size(sprite_size), .move_step(move_step)
   ) ctrl (
      .clock_50(clock_50), .rst(rst), .sof(timing.sof),
      .pad_p1(pad_p1), .pad_p2(pad_p2), .pos_p1(pos_p1), .pos_p2(pos_p2)
   );

   sprite_layer #(.sprite_size(sprite_size), .player_color(color_p1)) p1 (
      .clock_50(clock_50), .spot_x(timing.spot_x), .spot_y(timing.spot_y),
      .pos(pos_p1), .hit(hit_p1), .color(sprite_color_p1)
   );

   sprite_layer #(.sprite_size(sprite_size), .player_color(color_p2)) p2 (
      .clock_50(clock_50), .spot_x(timing.spot_x), .spot_y(timing.spot_y),
      .pos(pos_p2), .hit(hit_p2), .color(sprite_color_p2)
   );

   pixel_mixer mix (
      .clock_50(clock_50), .rst(rst), .timing(timing),
      .hit_p1(hit_p1), .color_p1_in(sprite_color_p1),
      .hit_p2(hit_p2), .color_p2_in(sprite_color_p2),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
   );

   assign debug = {24'd0, scan_byte};            // only the scan byte is shown

   hex_display hexd (.debug(debug), .hex(hex));

   assign hex0 = hex[0];
   assign hex1 = hex[1];
   assign hex2 = hex[2];
   assign hex3 = hex[3];
   assign hex4 = hex[4];
   assign hex5 = hex[5];
   assign hex6 = hex[6];
   assign hex7 = hex[7];

endmodule

// File: test/tb_bomber.sv
module tb_bomber;
   import game_pkg::*;

   localparam int h_act        = 64;
   localparam int v_act        = 48;
   localparam int h_sw         = 8;
   localparam int sq           = 8;                          // sprite_size
   localparam int step_px      = 2;                          // move_step
   localparam int frame_cycles = (64 + 4 + 8 + 4) * (48 + 2 + 2 + 2);
   localparam int wait_limit   = 2 * frame_cycles;
   localparam int ps2_half     = 20;                         // cycles per ps2 half period
   localparam logic [29:0] red_px   = {10'h3FF, 10'h000, 10'h000}; // E0 widened
   localparam logic [29:0] green_px = {10'h000, 10'h3FF, 10'h000}; // 1C widened

   logic       clock_50;
   logic       rst;
   logic       ps2_clk;
   logic       ps2_dat;
   logic       vga_hs;
   logic       vga_vs;
   logic       vga_blank;
   logic [9:0] vga_r;
   logic [9:0] vga_g;
   logic [9:0] vga_b;
   logic [6:0] hex0;
   logic [6:0] hex1;
   logic [6:0] hex2;
   logic [6:0] hex3;
   logic [6:0] hex4;
   logic [6:0] hex5;
   logic [6:0] hex6;
   logic [6:0] hex7;

   int          value_errors;
   int          other_errors;
   logic [31:0] lfsr;
   logic [29:0] pix [h_act*v_act];                           // {r, g, b} of one frame

   bomber_top #(
      .h_active(h_act), .h_front(4), .h_sync(h_sw), .h_back(4),
      .v_active(v_act), .v_front(2), .v_sync(2), .v_back(2),
      .sprite_size(sq), .move_step(step_px)
   ) dut (.*);

   initial begin
      clock_50 = 1'b0;
      forever #5 clock_50 = ~clock_50;
   end

   task automatic step();
      @(posedge clock_50);
      #1;                                                    // drive and sample past the edge
   endtask

   task automatic abort_run(input string why);
      other_errors++;
      $display("%s", why);
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         value_errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};         // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [6:0] seg_expect(input logic [3:0] n);
      case (n)                                               // g..a, active low
         4'h0:    return 7'b1000000;
         4'h1:    return 7'b1111001;
         4'h2:    return 7'b0100100;
         4'h3:    return 7'b0110000;
         4'h4:    return 7'b0011001;
         4'h5:    return 7'b0010010;
         4'h6:    return 7'b0000010;
         4'h7:    return 7'b1111000;
         4'h8:    return 7'b0000000;
         4'h9:    return 7'b0010000;
         4'hA:    return 7'b0001000;
         4'hB:    return 7'b0000011;
         4'hC:    return 7'b1000110;
         4'hD:    return 7'b0100001;
         4'hE:    return 7'b0000110;
         default: return 7'b0001110;
      endcase
   endfunction

   function automatic logic [9:0] widen(input logic [7:0] v);
      return {v, v[7:6]};                                    // top bits repeated below
   endfunction

   task automatic pick_hold(output int frames);
      frames = 2;
      for (int i = 0; i < 2; i++) begin
         lfsr   = lfsr_step(lfsr);                           // one step per bit
         frames = frames + (int'(lfsr[0]) << i);             // 2..5
      end
   endtask

   task automatic wait_vs(input logic level);
      int n;
      n = 0;
      while (vga_vs !== level) begin
         step();
         n++;
         if (n > wait_limit) abort_run("timeout waiting for vertical sync");
      end
   endtask

   task automatic wait_frames(input int count);
      repeat (count) begin
         wait_vs(1'b0);
         wait_vs(1'b1);
      end
   endtask

   task automatic send_ps2_byte(input logic [7:0] data, input logic bad_parity);
      logic [10:0] bits;
      bits = {1'b1, ~^data ^ bad_parity, data, 1'b0};        // stop, odd parity, data, start
      for (int i = 0; i < 11; i++) begin
         ps2_dat = bits[i];
         repeat (ps2_half) step();
         ps2_clk = 1'b0;                                     // receiver samples on this fall
         repeat (ps2_half) step();
         ps2_clk = 1'b1;
      end
      ps2_dat = 1'b1;
      repeat (ps2_half) step();                              // decode settles in 3 cycles
   endtask

   task automatic check_hex(input string name, input logic [7:0] b);
      logic [7:0][6:0] digits;
      digits = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};
      check({name, " hex0"}, 32'(seg_expect(b[3:0])), 32'(digits[0]));
      check({name, " hex1"}, 32'(seg_expect(b[7:4])), 32'(digits[1]));
      for (int i = 2; i < 8; i++) begin                      // upper bytes zero
         check($sformatf("%s hex%0d", name, i), 32'(seg_expect(4'h0)), 32'(digits[i]));
      end
   endtask

   task automatic send_byte(input string name, input logic [7:0] b);
      send_ps2_byte(b, 1'b0);
      check_hex(name, b);
   endtask

   task automatic scan_frame();
      int idx;
      int n;
      wait_vs(1'b0);
      wait_vs(1'b1);                                         // next frame is whole
      idx = 0;
      n   = 0;
      while (idx < h_act * v_act) begin
         step();
         n++;
         if (n > wait_limit) abort_run("timeout while recording a frame");
         if (vga_blank) begin
            pix[idx] = {vga_r, vga_g, vga_b};
            idx++;
         end
      end
   endtask

   task automatic find_square(input logic [29:0] color, output int x0, output int y0,
                              output int cnt);
      x0  = h_act;
      y0  = v_act;
      cnt = 0;
      for (int i = 0; i < h_act * v_act; i++) begin
         if (pix[i] == color) begin
            cnt++;
            if (i % h_act < x0) x0 = i % h_act;
            if (i / h_act < y0) y0 = i / h_act;
         end
      end
   endtask

   task automatic check_square(input string name, input logic [29:0] color,
                               input int ex, input int ey);
      int x0;
      int y0;
      int cnt;
      find_square(color, x0, y0, cnt);
      check({name, " x"}, ex, x0);
      check({name, " y"}, ey, y0);
      check({name, " size"}, sq * sq, cnt);                  // full square, nothing else
   endtask

   task automatic test_reset();
      rst = 1'b1;
      repeat (16) begin
         step();
         check("reset hs", 32'd1, 32'(vga_hs));
         check("reset vs", 32'd1, 32'(vga_vs));
         check("reset blank", 32'd0, 32'(vga_blank));
         check("reset color", 32'd0, 32'({vga_r, vga_g, vga_b}));
         check_hex("reset", 8'h00);
      end
      rst = 1'b0;
   endtask

   task automatic test_timing();
      int   n;
      int   blank_run;
      int   hs_run;
      int   lines;
      logic blank_q;
      logic hs_q;
      wait_vs(1'b0);
      wait_vs(1'b1);
      n         = 0;
      blank_run = 0;
      hs_run    = 0;
      lines     = 0;
      blank_q   = vga_blank;
      hs_q      = vga_hs;
      while (vga_vs) begin                                   // one frame up to next vsync
         step();
         n++;
         if (n > wait_limit) abort_run("timeout while measuring sync timing");
         if (vga_blank) blank_run++;
         if (!vga_hs) hs_run++;
         if (vga_blank && !blank_q) lines++;
         if (!vga_blank && blank_q) begin
            check("timing line width", h_act, blank_run);
            blank_run = 0;
         end
         if (vga_hs && !hs_q) begin
            check("timing hsync width", h_sw, hs_run);
            hs_run = 0;
         end
         blank_q = vga_blank;
         hs_q    = vga_hs;
      end
      check("timing active lines", v_act, lines);
   endtask

   task automatic test_background();
      int base;
      base = 20 * h_act;                                     // row clear of both squares
      for (int x = 0; x < h_act; x++) begin
         check("background red", 32'(widen(8'(x))), 32'(pix[base + x][29:20]));
         check("background green", 32'd0, 32'(pix[base + x][19:10]));
         check("background blue", 32'(widen(~8'(x))), 32'(pix[base + x][9:0]));
      end
   endtask

   task automatic test_movement();
      int hold;
      int x0;
      int y0;
      int cnt;
      int moved;
      pick_hold(hold);
      send_byte("move press D", sc_d);
      wait_frames(hold);
      send_byte("move break", sc_break);
      send_byte("move release D", sc_d);
      scan_frame();
      find_square(red_px, x0, y0, cnt);
      check("move p1 stepped", 32'd1, 32'(x0 > 0 && x0 % step_px == 0));
      check("move p1 y", 32'd0, y0);
      check("move p1 size", sq * sq, cnt);
      moved = x0;
      repeat (2) begin
         scan_frame();
         find_square(red_px, x0, y0, cnt);
         check("move p1 x held", moved, x0);                 // released key stays put
      end
      send_byte("clamp press A", sc_a);
      wait_frames(12);
      send_byte("clamp break", sc_break);
      send_byte("clamp release A", sc_a);
      send_byte("edge press L", sc_l);
      wait_frames(4);
      send_byte("edge break", sc_break);
      send_byte("edge release L", sc_l);
      scan_frame();
      check_square("clamp p1", red_px, 0, 0);
      check_square("edge p2", green_px, h_act - sq, v_act - sq);
   endtask

   task automatic test_bad_parity();
      send_byte("display 5A", 8'h5A);                        // unknown codes, digits only
      send_byte("display 29", 8'h29);
      send_byte("display 76", 8'h76);
      send_byte("display 0E", 8'h0E);
      send_byte("display 8D", 8'h8D);
      send_ps2_byte(sc_d, 1'b1);                             // would move p1 if taken
      check_hex("bad parity", 8'h8D);
      wait_frames(3);
      scan_frame();
      check_square("bad parity p1", red_px, 0, 0);
   endtask

   initial begin
      value_errors = 0;
      other_errors = 0;
      lfsr         = 32'h485e8945;
      rst          = 1'b1;
      ps2_clk      = 1'b1;                                   // bus idle
      ps2_dat      = 1'b1;
      test_reset();
      test_timing();
      scan_frame();
      test_background();
      check_square("start p1", red_px, 0, 0);
      check_square("start p2", green_px, h_act - sq, v_act - sq);
      test_movement();
      test_bad_parity();
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: tb.f
logic/game_pkg.sv
logic/vga_sync.sv
logic/ps2_keyboard.sv
logic/player_ctrl.sv
logic/sprite_layer.sv
logic/pixel_mixer.sv
logic/hex_display.sv
logic/bomber_top.sv
test/tb_bomber.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_bomber -f tb.f -o sim_bomber
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_bomber > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
